//--- source/rf_pkg.sv
package rf_pkg;

   // 32 serial bit cycles per register word.
   localparam int BIT_CNT_W = 5;

   // general registers 0..31, CSR registers from 32 up.
   typedef logic [5:0] reg_idx_t;

   typedef logic [2**BIT_CNT_W-1:0] word_t;

   typedef logic [2:0] alu_op_t;

   localparam alu_op_t ALU_ADD  = 3'd0;
   localparam alu_op_t ALU_SUB  = 3'd1;
   localparam alu_op_t ALU_XOR  = 3'd2;
   localparam alu_op_t ALU_AND  = 3'd3;
   // returns rs1, no write to rd.
   localparam alu_op_t ALU_PASS = 3'd4;

endpackage

//--- source/rf_ram_if.sv
`timescale 1ns/10ps

module rf_ram_if import rf_pkg::*; #(
   parameter int RF_WIDTH = 8,
   parameter int CSR_REGS = 4,
   localparam int DEPTH = 32 * (32 + CSR_REGS) / RF_WIDTH,
   localparam int AW = $clog2(DEPTH)
) (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_wreq,
   input  logic                i_rreq,
   output logic                o_ready,
   input  reg_idx_t            i_wreg0,
   input  reg_idx_t            i_wreg1,
   input  logic                i_wen0,
   input  logic                i_wen1,
   input  logic                i_wdata0,
   input  logic                i_wdata1,
   input  reg_idx_t            i_rreg0,
   input  reg_idx_t            i_rreg1,
   output logic                o_rdata0,
   output logic                o_rdata1,
   output logic [AW-1:0]       o_waddr,
   output logic [RF_WIDTH-1:0] o_wdata,
   output logic                o_wen,
   output logic [AW-1:0]       o_raddr,
   input  logic [RF_WIDTH-1:0] i_rdata
);

   localparam int L2W = $clog2(RF_WIDTH);

   logic rgnt;
   logic rreq_r;
   logic wreq_r;

   // write grant is immediate, read grant two cycles after the request.
   assign o_ready = rgnt | i_wreq;

   logic [BIT_CNT_W-1:0] wcnt;
   logic                 wgo;
   logic                 wen0_r;
   logic                 wen1_r;
   logic                 wtrig0;
   logic                 wtrig1;
   logic [RF_WIDTH-2:0]  wdata0_r;
   logic [RF_WIDTH-1:0]  wdata1_r;
   reg_idx_t             wreg;

   generate
      if (RF_WIDTH == 2) begin : g_wtrig_w2
         assign wtrig0 = ~wcnt[0];
         assign wtrig1 = wcnt[0];
      end else begin : g_wtrig
         logic wtrig0_r;

         // port 1 word goes out the cycle after port 0.
         always_ff @(posedge i_clk) begin
            if (i_rst) begin
               wtrig0_r <= 1'b0;
            end else begin
               wtrig0_r <= wtrig0;
            end
         end

         assign wtrig0 = (wcnt[L2W-1:0] == {{(L2W - 1){1'b1}}, 1'b0});
         assign wtrig1 = wtrig0_r;
      end
   endgenerate

   // port 0 word completes with the bit arriving this cycle.
   assign o_wdata = wtrig1 ? wdata1_r : {i_wdata0, wdata0_r};
   assign wreg    = wtrig1 ? i_wreg1 : i_wreg0;

   generate
      if (RF_WIDTH == 32) begin : g_waddr_w32
         assign o_waddr = wreg;
      end else begin : g_waddr
         assign o_waddr = {wreg, wcnt[BIT_CNT_W-1:L2W]};
      end
   endgenerate

   assign o_wen = wgo & ((wtrig0 & wen0_r) | (wtrig1 & wen1_r));

   generate
      if (RF_WIDTH > 2) begin : g_wsr
         always_ff @(posedge i_clk) begin
            wdata0_r <= {i_wdata0, wdata0_r[RF_WIDTH-2:1]};
         end
      end else begin : g_wsr_w2
         always_ff @(posedge i_clk) begin
            wdata0_r <= i_wdata0;
         end
      end
   endgenerate

   always_ff @(posedge i_clk) begin
      wdata1_r <= {i_wdata1, wdata1_r[RF_WIDTH-1:1]};
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wcnt   <= '0;
         wgo    <= 1'b0;
         wreq_r <= 1'b0;
         wen0_r <= 1'b0;
         wen1_r <= 1'b0;
      end else begin
         wen0_r <= i_wen0;
         wen1_r <= i_wen1;
         // a read grant also opens the write window for the result.
         wreq_r <= i_wreq | rgnt;
         if (wgo) begin
            wcnt <= wcnt + 1'b1;
         end
         if (wcnt == '1) begin
            wgo <= 1'b0;
         end else if (wreq_r) begin
            wgo <= 1'b1;
         end
      end
   end

   logic [BIT_CNT_W-1:0] rcnt;
   logic                 rtrig0;
   logic                 rtrig1;
   reg_idx_t             rreg;
   logic [RF_WIDTH-1:0]  rdata0;
   logic [RF_WIDTH-2:0]  rdata1;

   // rreg0 address on even slots, rreg1 on the slot after.
   assign rtrig0 = (rcnt[L2W-1:0] == L2W'(1));
   assign rreg   = rtrig0 ? i_rreg1 : i_rreg0;

   generate
      if (RF_WIDTH == 32) begin : g_raddr_w32
         assign o_raddr = rreg;
      end else begin : g_raddr
         assign o_raddr = {rreg, rcnt[BIT_CNT_W-1:L2W]};
      end
   endgenerate

   assign o_rdata0 = rdata0[0];
   // bit 0 of port 1 comes straight from the RAM.
   assign o_rdata1 = rtrig1 ? i_rdata[0] : rdata1[0];

   generate
      if (RF_WIDTH > 2) begin : g_rsr
         always_ff @(posedge i_clk) begin
            if (rtrig1) begin
               rdata1 <= i_rdata[RF_WIDTH-1:1];
            end else begin
               rdata1 <= {1'b0, rdata1[RF_WIDTH-2:1]};
            end
         end
      end else begin : g_rsr_w2
         always_ff @(posedge i_clk) begin
            if (rtrig1) begin
               rdata1 <= i_rdata[1];
            end
         end
      end
   endgenerate

   always_ff @(posedge i_clk) begin
      if (rtrig0) begin
         rdata0 <= i_rdata;
      end else begin
         rdata0 <= {1'b0, rdata0[RF_WIDTH-1:1]};
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rcnt   <= '0;
         rtrig1 <= 1'b0;
         rreq_r <= 1'b0;
         rgnt   <= 1'b0;
      end else begin
         rtrig1 <= rtrig0;
         rreq_r <= i_rreq;
         rgnt   <= rreq_r;
         if (i_rreq) begin
            rcnt <= '0;
         end else begin
            rcnt <= rcnt + 1'b1;
         end
      end
   end

endmodule

//--- source/rf_ram.sv
`timescale 1ns/10ps

module rf_ram #(
   parameter int RF_WIDTH = 8,
   parameter int CSR_REGS = 4,
   localparam int DEPTH = 32 * (32 + CSR_REGS) / RF_WIDTH,
   localparam int AW = $clog2(DEPTH)
) (
   input  logic                i_clk,
   input  logic [AW-1:0]       i_waddr,
   input  logic [RF_WIDTH-1:0] i_wdata,
   input  logic                i_wen,
   input  logic [AW-1:0]       i_raddr,
   output logic [RF_WIDTH-1:0] o_rdata
);

   logic [RF_WIDTH-1:0] mem [DEPTH];

   // read data one cycle after the address.
   always_ff @(posedge i_clk) begin
      if (i_wen) begin
         mem[i_waddr] <= i_wdata;
      end
      o_rdata <= mem[i_raddr];
   end

endmodule

//--- source/serial_alu.sv
`timescale 1ns/10ps

module serial_alu import rf_pkg::*; (
   input  logic    i_clk,
   input  logic    i_rst,
   input  logic    i_first,
   input  alu_op_t i_op,
   input  logic    i_a,
   input  logic    i_b,
   output logic    o_res
);

   logic carry;
   logic cin;
   logic b_in;
   logic sum;

   // subtract as a + ~b + 1.
   assign b_in = (i_op == ALU_SUB) ? ~i_b : i_b;
   assign cin  = i_first ? (i_op == ALU_SUB) : carry;
   assign sum  = i_a ^ b_in ^ cin;

   always_comb begin
      case (i_op)
         ALU_ADD,
         ALU_SUB: o_res = sum;
         ALU_XOR: o_res = i_a ^ i_b;
         ALU_AND: o_res = i_a & i_b;
         default: o_res = i_a;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry <= 1'b0;
      end else begin
         carry <= (i_a & b_in) | (cin & (i_a ^ b_in));
      end
   end

endmodule

//--- source/rf_sequencer.sv
`timescale 1ns/10ps

module rf_sequencer import rf_pkg::*; #(
   parameter int RF_WIDTH = 8
) (
   input  logic     i_clk,
   input  logic     i_rst,
   input  logic     i_start,
   input  logic     i_load,
   input  alu_op_t  i_op,
   input  reg_idx_t i_rs1,
   input  reg_idx_t i_rs2,
   input  reg_idx_t i_rd,
   input  word_t    i_data,
   output logic     o_rreq,
   output logic     o_wreq,
   output reg_idx_t o_rreg0,
   output reg_idx_t o_rreg1,
   output reg_idx_t o_wreg0,
   output logic     o_wen0,
   output logic     o_wdata0,
   input  logic     i_ready,
   output logic     o_alu_first,
   output alu_op_t  o_alu_op,
   input  logic     i_alu_res,
   output logic     o_busy,
   output logic     o_done,
   output word_t    o_result
);

   // covers the adapter's last RAM write.
   localparam int DRAIN_CYCLES = RF_WIDTH + 4;
   localparam int DRAIN_W = $clog2(DRAIN_CYCLES);

   typedef enum logic [2:0] {
      S_IDLE,
      S_REQ,
      S_WAIT_RDY,
      S_STREAM,
      S_DRAIN
   } state_t;

   state_t               state;
   logic [BIT_CNT_W-1:0] bit_cnt;
   logic [DRAIN_W-1:0]   drain_cnt;
   logic                 last_bit;
   logic                 last_drain;
   logic                 load_r;
   alu_op_t              op_r;
   reg_idx_t             rs1_r;
   reg_idx_t             rs2_r;
   reg_idx_t             rd_r;
   word_t                load_sr;
   word_t                res_sr;

   assign last_bit   = (bit_cnt == '1);
   assign last_drain = (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1));

   assign o_rreq = (state == S_REQ) && !load_r;
   // write grant is same cycle, so the load asks from the wait state.
   assign o_wreq = (state == S_WAIT_RDY) && load_r;

   assign o_rreg0 = rs1_r;
   assign o_rreg1 = rs2_r;
   assign o_wreg0 = rd_r;
   assign o_wen0  = (state == S_STREAM) && (load_r || op_r != ALU_PASS);
   assign o_wdata0 = load_r ? load_sr[0] : i_alu_res;

   assign o_alu_first = (state == S_STREAM) && (bit_cnt == '0);
   assign o_alu_op    = op_r;

   assign o_busy   = (state != S_IDLE);
   assign o_done   = (state == S_DRAIN) && last_drain;
   assign o_result = res_sr;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state     <= S_IDLE;
         bit_cnt   <= '0;
         drain_cnt <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (i_start) begin
                  state <= S_REQ;
               end
            end
            S_REQ: state <= S_WAIT_RDY;
            S_WAIT_RDY: begin
               if (i_ready) begin
                  state   <= S_STREAM;
                  bit_cnt <= '0;
               end
            end
            S_STREAM: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (last_bit) begin
                  state     <= S_DRAIN;
                  drain_cnt <= '0;
               end
            end
            S_DRAIN: begin
               drain_cnt <= drain_cnt + 1'b1;
               if (last_drain) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // command latch and serial shifters.
   always_ff @(posedge i_clk) begin
      if (state == S_IDLE && i_start) begin
         load_r  <= i_load;
         op_r    <= i_op;
         rs1_r   <= i_rs1;
         rs2_r   <= i_rs2;
         rd_r    <= i_rd;
         load_sr <= i_data;
      end else if (state == S_STREAM) begin
         load_sr <= {1'b0, load_sr[31:1]};
      end
      if (state == S_STREAM) begin
         res_sr <= {o_wdata0, res_sr[31:1]};
      end
   end

endmodule

//--- source/rf_core_top.sv
`timescale 1ns/10ps

module rf_core_top import rf_pkg::*; #(
   parameter int RF_WIDTH = 8,
   parameter int CSR_REGS = 4
) (
   input  logic     i_clk,
   input  logic     i_rst,
   input  logic     i_start,
   input  logic     i_load,
   input  alu_op_t  i_op,
   input  reg_idx_t i_rs1,
   input  reg_idx_t i_rs2,
   input  reg_idx_t i_rd,
   input  word_t    i_data,
   output logic     o_busy,
   output logic     o_done,
   output word_t    o_result
);

   localparam int DEPTH = 32 * (32 + CSR_REGS) / RF_WIDTH;
   localparam int AW = $clog2(DEPTH);

   logic                rreq;
   logic                wreq;
   logic                ready;
   reg_idx_t            rreg0;
   reg_idx_t            rreg1;
   reg_idx_t            wreg0;
   logic                wen0;
   logic                wdata0;
   logic                rdata0;
   logic                rdata1;
   logic                alu_first;
   alu_op_t             alu_op;
   logic                alu_res;
   logic [AW-1:0]       waddr;
   logic [RF_WIDTH-1:0] wdata;
   logic                wen;
   logic [AW-1:0]       raddr;
   logic [RF_WIDTH-1:0] rdata;

   rf_sequencer #(
      .RF_WIDTH (RF_WIDTH)
   ) u_seq (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_start     (i_start),
      .i_load      (i_load),
      .i_op        (i_op),
      .i_rs1       (i_rs1),
      .i_rs2       (i_rs2),
      .i_rd        (i_rd),
      .i_data      (i_data),
      .o_rreq      (rreq),
      .o_wreq      (wreq),
      .o_rreg0     (rreg0),
      .o_rreg1     (rreg1),
      .o_wreg0     (wreg0),
      .o_wen0      (wen0),
      .o_wdata0    (wdata0),
      .i_ready     (ready),
      .o_alu_first (alu_first),
      .o_alu_op    (alu_op),
      .i_alu_res   (alu_res),
      .o_busy      (o_busy),
      .o_done      (o_done),
      .o_result    (o_result)
   );

   serial_alu u_alu (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_first (alu_first),
      .i_op    (alu_op),
      .i_a     (rdata0),
      .i_b     (rdata1),
      .o_res   (alu_res)
   );

   // write port 1 is unused here.
   rf_ram_if #(
      .RF_WIDTH (RF_WIDTH),
      .CSR_REGS (CSR_REGS)
   ) u_ram_if (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_wreq   (wreq),
      .i_rreq   (rreq),
      .o_ready  (ready),
      .i_wreg0  (wreg0),
      .i_wreg1  ('0),
      .i_wen0   (wen0),
      .i_wen1   (1'b0),
      .i_wdata0 (wdata0),
      .i_wdata1 (1'b0),
      .i_rreg0  (rreg0),
      .i_rreg1  (rreg1),
      .o_rdata0 (rdata0),
      .o_rdata1 (rdata1),
      .o_waddr  (waddr),
      .o_wdata  (wdata),
      .o_wen    (wen),
      .o_raddr  (raddr),
      .i_rdata  (rdata)
   );

   rf_ram #(
      .RF_WIDTH (RF_WIDTH),
      .CSR_REGS (CSR_REGS)
   ) u_ram (
      .i_clk   (i_clk),
      .i_waddr (waddr),
      .i_wdata (wdata),
      .i_wen   (wen),
      .i_raddr (raddr),
      .o_rdata (rdata)
   );

endmodule

//--- test/rf_core_tb.sv
`timescale 1ns/10ps

module rf_core_tb import rf_pkg::*; ();

   localparam int RF_WIDTH = 8;
   localparam int NREGS = 36;
   // request, grant delay, 32 bits, drain, done.
   localparam int OP_LAT = 1 + 2 + 32 + RF_WIDTH + 4;
   localparam int LOAD_LAT = OP_LAT - 1;
   localparam int DONE_TIMEOUT = 200;

   logic     clk;
   logic     rst;
   logic     start;
   logic     load;
   alu_op_t  op;
   reg_idx_t rs1;
   reg_idx_t rs2;
   reg_idx_t rd;
   word_t    data;
   logic     busy;
   logic     done;
   word_t    result;

   word_t       shadow [NREGS];
   word_t       exp_result;
   string       test_name;
   int unsigned checks;
   int unsigned errors;
   int unsigned done_cnt;
   int unsigned cyc;
   int unsigned start_cyc;
   int unsigned lat_exp;
   logic        pending;
   logic        done_q;
   logic        rise_chk;

   rf_core_top #(
      .RF_WIDTH (RF_WIDTH),
      .CSR_REGS (4)
   ) DUT (
      .i_clk    (clk),
      .i_rst    (rst),
      .i_start  (start),
      .i_load   (load),
      .i_op     (op),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .i_rd     (rd),
      .i_data   (data),
      .o_busy   (busy),
      .o_done   (done),
      .o_result (result)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic word_t alu_ref(input alu_op_t f, input word_t a, input word_t b);
      case (f)
         ALU_ADD: return a + b;
         ALU_SUB: return a - b;
         ALU_XOR: return a ^ b;
         ALU_AND: return a & b;
         default: return a;
      endcase
   endfunction

   task automatic check_word(input string what, input word_t exp, input word_t act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
      end
   endtask

   task automatic end_run();
      $display("checks: %0d, errors: %0d, commands: %0d", checks, errors, done_cnt);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   endtask

   // poke_at > 0 pulses a stray start that many cycles into the command.
   task automatic run_cmd(input logic ld, input alu_op_t f, input reg_idx_t a,
                          input reg_idx_t b, input reg_idx_t d, input word_t w,
                          input word_t exp, input int poke_at);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      start = 1'b1;
      load = ld;
      op = f;
      rs1 = a;
      rs2 = b;
      rd = d;
      data = w;
      exp_result = exp;
      @(posedge clk);
      #1;
      start = 1'b0;
      while (!done && n < DONE_TIMEOUT) begin
         @(posedge clk);
         #1;
         n++;
         if (poke_at != 0 && n == poke_at) begin
            start = 1'b1;
            load = ~ld;
            op = ALU_XOR;
            rd = d ^ 6'd1;
            data = ~w;
         end else begin
            start = 1'b0;
         end
      end
      if (n >= DONE_TIMEOUT) begin
         errors++;
         $display("timeout: o_done did not arrive within %0d cycles in test %s",
                  DONE_TIMEOUT, test_name);
         end_run();
      end
   endtask

   // per-cycle checks of status, latency and result.
   always @(posedge clk) begin
      if (rst) begin
         cyc <= 0;
         pending <= 1'b0;
         done_q <= 1'b0;
         rise_chk <= 1'b0;
      end else begin
         cyc <= cyc + 1;
         done_q <= done;
         rise_chk <= 1'b0;
         if (rise_chk) begin
            check_word("o_busy after start", 1, busy);
         end
         if (!pending) begin
            check_word("o_busy while idle", 0, busy);
            check_word("o_done while idle", 0, done);
         end
         if (start && !pending) begin
            start_cyc <= cyc;
            pending <= 1'b1;
            rise_chk <= 1'b1;
            lat_exp <= load ? LOAD_LAT : OP_LAT;
         end
         if (done && pending) begin
            pending <= 1'b0;
            done_cnt++;
            check_word("latency", lat_exp, cyc - start_cyc);
            check_word("o_result", exp_result, result);
            check_word("o_done width", 0, done_q);
         end
      end
   end

   initial begin
      int unsigned a;
      int unsigned b;
      int unsigned d;
      word_t       w;
      word_t       exp;
      alu_op_t     f;
      checks = 0;
      errors = 0;
      done_cnt = 0;
      rst = 1'b1;
      start = 1'b0;
      load = 1'b0;
      op = ALU_ADD;
      rs1 = '0;
      rs2 = '0;
      rd = '0;
      data = '0;
      exp_result = '0;
      test_name = "reset";
      void'($urandom(56151));
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      repeat (8) @(posedge clk);

      test_name = "load";
      for (int i = 0; i < NREGS; i++) begin
         w = $urandom;
         shadow[i] = w;
         run_cmd(1'b1, ALU_ADD, '0, '0, reg_idx_t'(i), w, w, 0);
      end

      // rd points at a neighbour, which must stay untouched.
      test_name = "pass";
      for (int i = 0; i < NREGS; i++) begin
         run_cmd(1'b0, ALU_PASS, reg_idx_t'(i), reg_idx_t'($urandom_range(35, 0)),
                 reg_idx_t'((i + 1) % NREGS), $urandom, shadow[i], 0);
      end
      test_name = "pass_again";
      for (int i = 0; i < NREGS; i++) begin
         run_cmd(1'b0, ALU_PASS, reg_idx_t'(i), '0, reg_idx_t'(i), '0, shadow[i], 0);
      end

      test_name = "arith";
      repeat (40) begin
         a = $urandom_range(35, 0);
         b = $urandom_range(35, 0);
         d = $urandom_range(35, 0);
         f = alu_op_t'($urandom_range(3, 0));
         exp = alu_ref(f, shadow[a], shadow[b]);
         run_cmd(1'b0, f, reg_idx_t'(a), reg_idx_t'(b), reg_idx_t'(d), '0, exp, 0);
         shadow[d] = exp;
         run_cmd(1'b0, ALU_PASS, reg_idx_t'(d), '0, '0, '0, shadow[d], 0);
      end

      test_name = "reuse";
      for (int k = 0; k < 12; k++) begin
         a = $urandom_range(35, 0);
         b = $urandom_range(35, 0);
         if (k % 3 == 0) begin
            d = a;
         end else if (k % 3 == 1) begin
            d = b;
         end else begin
            b = a;
            d = a;
         end
         f = alu_op_t'(k % 4);
         exp = alu_ref(f, shadow[a], shadow[b]);
         run_cmd(1'b0, f, reg_idx_t'(a), reg_idx_t'(b), reg_idx_t'(d), '0, exp, 0);
         shadow[d] = exp;
         run_cmd(1'b0, ALU_PASS, reg_idx_t'(d), '0, '0, '0, shadow[d], 0);
      end

      test_name = "timing";
      a = $urandom_range(35, 0);
      b = $urandom_range(35, 0);
      d = $urandom_range(35, 0);
      exp = alu_ref(ALU_ADD, shadow[a], shadow[b]);
      run_cmd(1'b0, ALU_ADD, reg_idx_t'(a), reg_idx_t'(b), reg_idx_t'(d), '0, exp, 10);
      shadow[d] = exp;
      run_cmd(1'b0, ALU_PASS, reg_idx_t'(d ^ 1), '0, '0, '0, shadow[d ^ 1], 0);
      d = $urandom_range(35, 0);
      w = $urandom;
      run_cmd(1'b1, ALU_ADD, '0, '0, reg_idx_t'(d), w, w, 40);
      shadow[d] = w;
      run_cmd(1'b0, ALU_PASS, reg_idx_t'(d), '0, '0, '0, shadow[d], 0);
      run_cmd(1'b0, ALU_PASS, reg_idx_t'(d ^ 1), '0, '0, '0, shadow[d ^ 1], 0);

      // nothing may start during the idle tail.
      repeat (20) @(posedge clk);
      end_run();
   end

endmodule

//--- list.f
source/rf_pkg.sv
source/rf_ram_if.sv
source/rf_ram.sv
source/serial_alu.sv
source/rf_sequencer.sv
source/rf_core_top.sv
test/rf_core_tb.sv
